//--- common/cc_consts.svh
`ifndef CC_CONSTS_SVH
`define CC_CONSTS_SVH

// rate limits
`define CC_RATE_LINE    16'd65535  // line rate, reset value of both rates
`define CC_RAI          16'd512    // additive increase step

// alpha
`define CC_ALPHA_INIT   9'd256     // 1.0
`define CC_G            9'd16      // gain of 1/16 in alpha units

// periods in cycles
`define CC_MIN_DEC_GAP  8'd50      // decreases closer than this are dropped
`define CC_ALPHA_PERIOD 8'd55      // no mark for this long decays alpha
`define CC_INC_PERIOD   8'd100     // timer driven increase event

// thresholds
`define CC_F            3'd5       // fast recovery steps, unmarked count per increase

// request queue
`define CC_QDEPTH       16

`endif

//--- common/cc_pkg.sv
`default_nettype none

package cc_pkg;

    // release rate, fraction of one request per cycle in 1/65536 steps
    typedef logic [15:0] rate_t;

    // congestion estimate, 256 is 1.0
    typedef logic [8:0] alpha_t;

    typedef logic [7:0] cyc_cnt_t;   // cycle timers of the controller
    typedef logic [2:0] step_cnt_t;  // recovery steps and unmarked notifications

    typedef logic [1:0]  opcode_t;
    typedef logic [9:0]  qpn_t;
    typedef logic [47:0] vaddr_t;
    typedef logic [11:0] len_t;

    // send request as it travels through the queue, 72 bits
    typedef struct packed {
        opcode_t opcode;
        qpn_t    qpn;
        vaddr_t  vaddr;
        len_t    len;
    } dreq_t;

    // increase phase of the rate controller
    typedef enum logic {
        ST_FAST_RECOVERY,
        ST_ADDITIVE
    } cc_stage_t;

endpackage

`default_nettype wire

//--- dv/cc_queue_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cc_queue_assertions (
    input wire                aclk,
    input wire                aresetn,
    input wire                m_req_valid,
    input wire                m_req_ready,
    input wire cc_pkg::dreq_t m_req_data,
    input wire                ecn_ready
);

    int error_count = 0;  // read by the testbench at the end

    // stalled output keeps its request
    hold_output: assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid && !m_req_ready |=> m_req_valid && $stable(m_req_data))
    else begin
        $error("m_req_data or m_req_valid changed while the output was stalled");
        error_count++;
    end

    quiet_in_reset: assert property (@(posedge aclk)
        !aresetn |=> !m_req_valid)
    else begin
        $error("m_req_valid high during reset");
        error_count++;
    end

    // pause after a decrease lasts one cycle only
    short_pause: assert property (@(posedge aclk) disable iff (!aresetn)
        !ecn_ready |=> ecn_ready)
    else begin
        $error("ecn_ready low for two cycles in a row");
        error_count++;
    end

endmodule

bind cc_queue cc_queue_assertions u_assertions (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data),
    .ecn_ready   (ecn_ready)
);

`default_nettype wire

//--- dv/cc_queue_ref.svh
`ifndef CC_QUEUE_REF_SVH
`define CC_QUEUE_REF_SVH

`include "cc_consts.svh"

// controller state as the model tracks it
typedef struct packed {
    cc_pkg::rate_t     cur;
    cc_pkg::rate_t     tgt;
    cc_pkg::alpha_t    alpha;
    cc_pkg::cc_stage_t stage;
    cc_pkg::step_cnt_t steps;
    cc_pkg::step_cnt_t unmarked;
    cc_pkg::cyc_cnt_t  timer;
    cc_pkg::cyc_cnt_t  since_dec;
    cc_pkg::cyc_cnt_t  since_mark;
    logic              ready;
} cc_model_t;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic cc_model_t cc_model_reset();
    cc_model_t s;
    s            = '0;
    s.cur        = `CC_RATE_LINE;
    s.tgt        = `CC_RATE_LINE;
    s.alpha      = `CC_ALPHA_INIT;
    s.stage      = cc_pkg::ST_FAST_RECOVERY;
    s.ready      = 1'b1;
    return s;
endfunction

// one clock edge of the rate rules, given the notification seen at that edge
function automatic cc_model_t cc_rate_step(input cc_model_t s, input logic valid,
                                           input logic mark);
    cc_model_t n;
    logic      marked;
    logic      clean;
    logic      dec;
    logic      decay;
    logic      timer_hit;
    logic      count_hit;
    int        cur;
    int        tgt;
    int        alpha;
    int        grown;
    n      = s;
    cur    = s.cur;
    tgt    = s.tgt;
    alpha  = s.alpha;
    marked = valid && s.ready && mark;
    clean  = valid && s.ready && !mark;
    dec    = marked && (s.since_dec > `CC_MIN_DEC_GAP);
    decay  = !marked && (s.since_mark == `CC_ALPHA_PERIOD);

    n.ready      = !dec;
    n.since_mark = (marked || decay) ? 8'd0 : s.since_mark + 8'd1;
    if (s.since_dec != '1) begin
        n.since_dec = s.since_dec + 8'd1;
    end
    if (decay) begin
        n.alpha = cc_pkg::alpha_t'((240 * alpha) >> 8);
    end

    if (dec) begin
        n.tgt       = s.cur;
        n.cur       = cc_pkg::rate_t'(cur - ((cur * alpha) >> 9));
        n.alpha     = cc_pkg::alpha_t'((((256 - `CC_G) * alpha) >> 8) + `CC_G);
        n.stage     = cc_pkg::ST_FAST_RECOVERY;
        n.steps     = '0;
        n.unmarked  = '0;
        n.timer     = '0;
        n.since_dec = '0;
    end else begin
        timer_hit  = (s.timer == `CC_INC_PERIOD);
        count_hit  = (s.unmarked == `CC_F);
        n.timer    = timer_hit ? 8'd0 : s.timer + 8'd1;
        n.unmarked = count_hit ? {2'b00, clean} : s.unmarked + {2'b00, clean};
        if (timer_hit || count_hit) begin
            if (s.stage == cc_pkg::ST_FAST_RECOVERY) begin
                n.cur   = cc_pkg::rate_t'((cur + tgt) >> 1);
                n.steps = s.steps + 3'd1;
                if (n.steps == `CC_F) begin
                    n.stage = cc_pkg::ST_ADDITIVE;
                end
            end else begin
                grown = tgt + `CC_RAI;
                if (grown > `CC_RATE_LINE) begin
                    grown = `CC_RATE_LINE;
                end
                n.tgt = cc_pkg::rate_t'(grown);
                n.cur = cc_pkg::rate_t'((cur + grown) >> 1);
            end
        end
    end
    return n;
endfunction

`endif

//--- dv/cc_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

module cc_queue_tb;

    localparam int RESET_CYCLES  = 10;
    localparam int RANDOM_CYCLES = 1500;
    localparam int SPACED_MARKS  = 6;
    localparam int IDLE_CYCLES   = 16000;
    localparam int DOWN_MARKS    = 12;
    localparam int PACE_WINDOW   = 2000;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + RANDOM_CYCLES + SPACED_MARKS * 130
                                 + IDLE_CYCLES + DOWN_MARKS * 60 + PACE_WINDOW + 400;
    localparam int RDY_LOW       = 0;
    localparam int RDY_RANDOM    = 1;
    localparam int RDY_HIGH      = 2;

    logic          aclk;
    logic          aresetn;
    logic          s_req_valid;
    cc_pkg::dreq_t s_req_data;
    logic          s_req_ready;
    logic          m_req_valid;
    cc_pkg::dreq_t m_req_data;
    logic          m_req_ready;
    logic          ecn_valid;
    logic          ecn_mark;
    logic          ecn_ready;
    cc_pkg::rate_t cur_rate;

    logic [31:0]   rng = 32'hb1d9;
    int            ready_mode = RDY_LOW;
    logic          src_on = 1'b0;
    logic          src_dense = 1'b0;
    cc_pkg::dreq_t sb[$];           // requests accepted and not yet seen at the output
    int            edge_no = 0;
    int            pace_start = 32'h3fff_ffff;
    longint        rate_sum = 0;
    int            releases = 0;

    `include "cc_queue_ref.svh"

    cc_queue u_cc_queue (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_data  (s_req_data),
        .s_req_ready (s_req_ready),
        .m_req_valid (m_req_valid),
        .m_req_data  (m_req_data),
        .m_req_ready (m_req_ready),
        .ecn_valid   (ecn_valid),
        .ecn_mark    (ecn_mark),
        .ecn_ready   (ecn_ready),
        .cur_rate    (cur_rate)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rate(input string name, input cc_pkg::rate_t expected,
                              input cc_pkg::rate_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected %0d got %0d",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_req(input string name, input cc_pkg::dreq_t expected,
                             input cc_pkg::dreq_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected %h got %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected %b got %b",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic cc_pkg::dreq_t make_req();
        cc_pkg::dreq_t req;
        logic [31:0]   hi;
        logic [31:0]   lo;
        hi         = rand32();
        lo         = rand32();
        req.opcode = hi[1:0];
        req.qpn    = hi[11:2];
        req.len    = hi[23:12];
        req.vaddr  = {hi[31:16], lo};
        return req;
    endfunction

    task automatic send_ecn(input logic mark);
        @(negedge aclk);
        ecn_valid = 1'b1;
        ecn_mark  = mark;
        while (!ecn_ready) @(negedge aclk);  // ready seen here holds through the next edge
        @(negedge aclk);
        ecn_valid = 1'b0;
    endtask

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial begin
        #(TOTAL_CYCLES * 4 * 100);
        fail_run($sformatf("Watchdog expired: stimulus did not finish within %0d cycles",
                           TOTAL_CYCLES * 4));
    end

    // request source and output stalls
    initial begin : drive
        logic [31:0] r;
        logic        ready_seen;
        ready_seen = 1'b0;
        forever begin
            @(negedge aclk);
            r = rand32();
            case (ready_mode)
                RDY_LOW:    m_req_ready = 1'b0;
                RDY_RANDOM: m_req_ready = r[0] | r[1];
                default:    m_req_ready = 1'b1;
            endcase
            if (s_req_valid && ready_seen) begin
                s_req_valid = 1'b0;  // taken at the last edge
            end
            if (!s_req_valid && src_on && (src_dense || r[2])) begin
                s_req_valid = 1'b1;
                s_req_data  = make_req();
            end
            ready_seen = s_req_ready;
        end
    end

    // compares outputs at the falling edge, updates model and scoreboard at the rising edge
    initial begin : compare
        cc_model_t     model;
        logic          model_live;
        logic          in_reset;
        logic          mv;
        logic          sr;
        cc_pkg::dreq_t md;
        model_live = 1'b0;
        in_reset   = 1'b1;
        forever begin
            @(negedge aclk);
            if (model_live) begin
                check_rate("cur_rate", model.cur, cur_rate);
                check_bit("ecn_ready", model.ready, ecn_ready);
                if (in_reset) begin
                    check_bit("m_req_valid", 1'b0, m_req_valid);
                end
            end
            mv = m_req_valid;
            md = m_req_data;
            sr = s_req_ready;
            @(posedge aclk);
            edge_no  = edge_no + 1;
            in_reset = !aresetn;
            if (edge_no >= pace_start && edge_no < pace_start + PACE_WINDOW) begin
                rate_sum = rate_sum + model.cur;
            end
            if (in_reset) begin
                model      = cc_model_reset();
                model_live = 1'b1;
            end else begin
                model = cc_rate_step(model, ecn_valid, ecn_mark);
                if (s_req_valid && sr) begin
                    sb.push_back(s_req_data);
                end
                if (mv && m_req_ready) begin
                    if (sb.size() == 0) begin
                        fail_run("Output released a request that was never accepted");
                    end
                    check_req("m_req_data", sb.pop_front(), md);
                    if (edge_no >= pace_start + 2 && edge_no < pace_start + PACE_WINDOW + 2) begin
                        releases = releases + 1;  // carries lead releases by two edges
                    end
                end
            end
        end
    end

    initial begin : main
        longint expected;
        aresetn     = 1'b0;
        s_req_valid = 1'b0;
        s_req_data  = '0;
        m_req_ready = 1'b0;
        ecn_valid   = 1'b0;
        ecn_mark    = 1'b0;
        repeat (RESET_CYCLES) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        check_bit("m_req_valid", 1'b0, m_req_valid);
        check_bit("s_req_ready", 1'b1, s_req_ready);
        check_bit("ecn_ready", 1'b1, ecn_ready);
        check_rate("cur_rate", `CC_RATE_LINE, cur_rate);

        // fill with the output stalled, one request sits in the output register
        src_dense = 1'b1;
        src_on    = 1'b1;
        while (s_req_ready) @(negedge aclk);
        if (sb.size() != `CC_QDEPTH + 1) begin
            fail_run($sformatf("Full queue holds %0d requests in flight instead of %0d",
                               sb.size(), `CC_QDEPTH + 1));
        end

        src_dense  = 1'b0;
        ready_mode = RDY_RANDOM;
        repeat (RANDOM_CYCLES) @(negedge aclk);
        src_on     = 1'b0;
        ready_mode = RDY_HIGH;
        while (sb.size() != 0 || s_req_valid) @(negedge aclk);

        // spaced decreases, each followed by a mark inside the gap
        repeat (SPACED_MARKS) begin
            send_ecn(1'b1);
            send_ecn(1'b1);
            repeat (60) @(negedge aclk);
        end

        repeat (12) send_ecn(1'b0);
        repeat (IDLE_CYCLES) @(negedge aclk);
        send_ecn(1'b1);  // decayed alpha makes this one small

        src_on    = 1'b1;
        src_dense = 1'b1;
        repeat (DOWN_MARKS) begin
            send_ecn(1'b1);
            repeat (52) @(negedge aclk);
        end
        pace_start = edge_no + 2;
        while (edge_no < pace_start + PACE_WINDOW + 1) @(negedge aclk);
        expected = rate_sum / 65536;
        if (releases < expected - 1 || releases > expected + 1) begin
            fail_run($sformatf("Pacing released %0d requests in %0d cycles, expected %0d",
                               releases, PACE_WINDOW, expected));
        end

        src_on = 1'b0;
        while (sb.size() != 0 || s_req_valid) @(negedge aclk);
        repeat (5) @(negedge aclk);

        if (u_cc_queue.u_assertions.error_count != 0) begin
            fail_run("Assertions on the queue ports failed during the run");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- rate_ctrl/cc_rate_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

module cc_rate_ctrl (
    input  wire                aclk,
    input  wire                aresetn,
    input  wire                ecn_valid,
    input  wire                ecn_mark,
    output logic               ecn_ready,
    output cc_pkg::rate_t      cur_rate
);

    cc_pkg::rate_t     rt;            // target rate
    cc_pkg::alpha_t    alpha;
    cc_pkg::cc_stage_t stage;
    cc_pkg::step_cnt_t step_cnt;
    cc_pkg::step_cnt_t unmarked_cnt;
    cc_pkg::cyc_cnt_t  inc_timer;
    cc_pkg::cyc_cnt_t  dec_gap;       // saturates, cycles since last decrease
    cc_pkg::cyc_cnt_t  mark_age;      // cycles since last accepted mark

    logic              accept;
    logic              mark_acc;
    logic              unmarked_acc;
    logic              do_dec;
    logic              inc_event;
    logic              decay;

    logic [24:0]       dec_prod;
    logic [16:0]       alpha_prod;
    cc_pkg::alpha_t    alpha_scaled;
    logic [16:0]       mean_sum;
    logic [16:0]       rt_sum;
    cc_pkg::rate_t     rt_add;
    logic [16:0]       add_sum;

    always_comb begin
        accept       = ecn_valid && ecn_ready;
        mark_acc     = accept && ecn_mark;
        unmarked_acc = accept && !ecn_mark;

        do_dec    = mark_acc && (dec_gap > `CC_MIN_DEC_GAP);
        inc_event = (inc_timer == `CC_INC_PERIOD) || (unmarked_cnt == `CC_F);
        decay     = !mark_acc && (mark_age == `CC_ALPHA_PERIOD);

        dec_prod     = cur_rate * alpha;
        alpha_prod   = (9'd256 - `CC_G) * alpha;  // shared by decrease and decay
        alpha_scaled = alpha_prod[16:8];

        mean_sum = cur_rate + rt;
        rt_sum   = rt + `CC_RAI;
        rt_add   = (rt_sum > `CC_RATE_LINE) ? `CC_RATE_LINE : rt_sum[15:0];
        add_sum  = cur_rate + rt_add;  // mean with the grown target
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ecn_ready    <= 1'b1;
            cur_rate     <= `CC_RATE_LINE;
            rt           <= `CC_RATE_LINE;
            alpha        <= `CC_ALPHA_INIT;
            stage        <= cc_pkg::ST_FAST_RECOVERY;
            step_cnt     <= '0;
            unmarked_cnt <= '0;
            inc_timer    <= '0;
            dec_gap      <= '0;
            mark_age     <= '0;
        end else begin
            ecn_ready <= !do_dec;  // one cycle pause after a decrease

            if (dec_gap != '1) begin
                dec_gap <= dec_gap + 1'b1;
            end

            if (mark_acc || decay) begin
                mark_age <= '0;
            end else begin
                mark_age <= mark_age + 1'b1;
            end

            if (decay) begin
                alpha <= alpha_scaled;
            end

            if (do_dec) begin
                rt           <= cur_rate;
                cur_rate     <= cur_rate - dec_prod[24:9];
                alpha        <= alpha_scaled + `CC_G;
                stage        <= cc_pkg::ST_FAST_RECOVERY;
                step_cnt     <= '0;
                unmarked_cnt <= '0;
                inc_timer    <= '0;
                dec_gap      <= '0;
            end else begin
                inc_timer    <= inc_timer + 1'b1;
                unmarked_cnt <= unmarked_cnt + cc_pkg::step_cnt_t'(unmarked_acc);

                if (inc_event) begin
                    // only the counter that fired starts over
                    if (inc_timer == `CC_INC_PERIOD) begin
                        inc_timer <= '0;
                    end
                    if (unmarked_cnt == `CC_F) begin
                        unmarked_cnt <= cc_pkg::step_cnt_t'(unmarked_acc);
                    end

                    if (stage == cc_pkg::ST_FAST_RECOVERY) begin
                        cur_rate <= mean_sum[16:1];
                        step_cnt <= step_cnt + 1'b1;
                        if (step_cnt == `CC_F - 3'd1) begin
                            stage <= cc_pkg::ST_ADDITIVE;
                        end
                    end else begin
                        rt       <= rt_add;
                        cur_rate <= add_sum[16:1];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/cc_pacer.sv
`timescale 1ns/1ps
`default_nettype none

module cc_pacer (
    input  wire                aclk,
    input  wire                aresetn,

    input  wire cc_pkg::rate_t cur_rate,

    input  wire                q_valid,
    input  wire cc_pkg::dreq_t q_data,
    output logic               q_ready,

    output logic               m_req_valid,
    output cc_pkg::dreq_t      m_req_data,
    input  wire                m_req_ready
);

    cc_pkg::rate_t acc;      // phase accumulator
    cc_pkg::rate_t acc_sum;
    logic          carry;
    logic          credit;   // at most one banked release
    logic          out_held;
    logic          take;

    always_comb begin
        {carry, acc_sum} = acc + cur_rate;
        out_held         = m_req_valid && !m_req_ready;
        take             = credit && q_valid && !out_held;
        q_ready          = take;
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            acc         <= '0;
            credit      <= 1'b0;
            m_req_valid <= 1'b0;
        end else begin
            acc <= acc_sum;

            if (take) begin
                credit <= carry;  // a fresh carry refills the spent credit
            end else begin
                credit <= credit || carry;
            end

            if (take) begin
                m_req_valid <= 1'b1;
            end else if (m_req_ready) begin
                m_req_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            m_req_data <= q_data;
        end
    end

endmodule

`default_nettype wire

//--- src/cc_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "cc_consts.svh"

module cc_queue (
    input  wire                aclk,
    input  wire                aresetn,

    input  wire                s_req_valid,
    input  wire cc_pkg::dreq_t s_req_data,
    output wire                s_req_ready,

    output wire                m_req_valid,
    output wire cc_pkg::dreq_t m_req_data,
    input  wire                m_req_ready,

    input  wire                ecn_valid,
    input  wire                ecn_mark,
    output wire                ecn_ready,

    output wire cc_pkg::rate_t cur_rate      // monitoring
);

    wire                q_valid;
    wire cc_pkg::dreq_t q_data;
    wire                q_ready;

    cc_rate_ctrl u_rate_ctrl (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ecn_valid (ecn_valid),
        .ecn_mark  (ecn_mark),
        .ecn_ready (ecn_ready),
        .cur_rate  (cur_rate)
    );

    cc_req_fifo #(
        .QDEPTH (`CC_QDEPTH)
    ) u_req_fifo (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_data  (s_req_data),
        .s_req_ready (s_req_ready),
        .q_valid     (q_valid),
        .q_data      (q_data),
        .q_ready     (q_ready)
    );

    cc_pacer u_pacer (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .cur_rate    (cur_rate),
        .q_valid     (q_valid),
        .q_data      (q_data),
        .q_ready     (q_ready),
        .m_req_valid (m_req_valid),
        .m_req_data  (m_req_data),
        .m_req_ready (m_req_ready)
    );

endmodule

`default_nettype wire

//--- src/cc_req_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cc_req_fifo #(
    parameter int unsigned QDEPTH = 16  // power of two, at least 2
) (
    input  wire                aclk,
    input  wire                aresetn,

    input  wire                s_req_valid,
    input  wire cc_pkg::dreq_t s_req_data,
    output logic               s_req_ready,

    output logic               q_valid,
    output cc_pkg::dreq_t      q_data,
    input  wire                q_ready
);

    localparam int unsigned AW = $clog2(QDEPTH);
    localparam int unsigned CW = $clog2(QDEPTH + 1);

    cc_pkg::dreq_t mem [QDEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic          wr_en;
    logic          rd_en;

    always_comb begin
        s_req_ready = (count != CW'(QDEPTH));
        q_valid     = (count != '0);
        q_data      = mem[rd_ptr];
        wr_en       = s_req_valid && s_req_ready;
        rd_en       = q_valid && q_ready;
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_req_data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps on its own
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
+incdir+dv
common/cc_pkg.sv
rate_ctrl/cc_rate_ctrl.sv
src/cc_req_fifo.sv
src/cc_pacer.sv
src/cc_queue.sv
dv/cc_queue_assertions.sv
dv/cc_queue_tb.sv
